// ==== cart_loader_consts.svh ====
// ==============================
// Cartridge loader constants
// File kinds, CRT header offsets, load base and address widths
// ==============================
`ifndef CART_LOADER_CONSTS_SVH
`define CART_LOADER_CONSTS_SVH

// External memory address width
`define LOAD_ADDR_W 25

// Download index values from the host
`define IDX_PRG 8'h02
`define IDX_CRT 8'h03
`define IDX_CRT_ALT 8'hC0

// CRT file header offsets
`define CRT_HDR_ID_HI 25'h16
`define CRT_HDR_ID_LO 25'h17
`define CRT_HDR_EXROM 25'h18
`define CRT_HDR_GAME 25'h19

// First chip block follows the 64 byte file header
`define CRT_CHIP_START 25'h40

// Cartridge data region and its bank alignment (8 KB)
`define CRT_BASE_ADDR 25'h100000
`define CRT_ALIGN_BITS 13

// CHIP packet header length in bytes
`define CHIP_HDR_LEN 16

`endif

// ==== cart_loader_pkg.sv ====
// ==============================
// Cartridge loader types
// Download kinds, load commands and CRT bank records
// ==============================
`default_nettype none

package cart_loader_pkg;

	// Kind of the download in progress
	typedef enum logic [1:0] {
		DL_NONE = 2'd0,
		DL_PRG  = 2'd1,
		DL_CRT  = 2'd2
	} dl_kind_e;

	// Operations on the load address and the memory write path
	typedef enum logic [2:0] {
		OP_NONE     = 3'd0,
		OP_SET_LO   = 3'd1,
		OP_SET_HI   = 3'd2,
		OP_SET_BASE = 3'd3,
		OP_ALIGN    = 3'd4,
		OP_WRITE    = 3'd5
	} load_op_e;

	typedef struct packed {
		load_op_e   op;
		logic [7:0] data;
	} load_cmd_t;

	// One CHIP packet header, fields big-endian in the file
	typedef struct packed {
		logic [7:0]  bank_type;
		logic [15:0] bank_num;
		logic [15:0] load_addr;
		logic [15:0] size;
	} crt_bank_t;

endpackage

`default_nettype wire

// ==== cart_loader_top.sv ====
// ==============================
// Cartridge loader top level
// ==============================
`timescale 1ns/1ns
`default_nettype none

`include "cart_loader_consts.svh"

module cart_loader_top (
	input  wire                         clk_sys,
	input  wire                         reset_n,
	input  wire                         dl_active_i,
	input  wire [7:0]                   dl_index_i,
	input  wire [`LOAD_ADDR_W-1:0]      dl_addr_i,
	input  wire [7:0]                   dl_data_i,
	input  wire                         dl_wr_i,
	input  wire                         slot_i,
	input  wire [`LOAD_ADDR_W-1:0]      host_addr_i,
	input  wire                         host_ce_i,
	input  wire                         host_we_i,
	input  wire [7:0]                   host_data_i,
	input  wire                         detach_i,
	output wire                         dl_wait_o,
	output wire [`LOAD_ADDR_W-1:0]      mem_addr_o,
	output wire                         mem_ce_o,
	output wire                         mem_we_o,
	output wire [7:0]                   mem_data_o,
	output wire [15:0]                  cart_id_o,
	output wire [7:0]                   cart_exrom_o,
	output wire [7:0]                   cart_game_o,
	output cart_loader_pkg::crt_bank_t  bank_o,
	output wire [`LOAD_ADDR_W-1:0]      bank_raddr_o,
	output wire                         bank_wr_o,
	output wire                         cart_attached_o
);

	cart_loader_pkg::load_cmd_t load_cmd;
	cart_loader_pkg::dl_kind_e  dl_kind;
	cart_loader_pkg::crt_bank_t chip_hdr;
	wire                        dl_done;
	wire                        chip_hdr_done;
	wire [`LOAD_ADDR_W-1:0]     load_addr;

	// Input side
	dl_stream_decoder u_dl_stream_decoder (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.dl_active_i     (dl_active_i),
		.dl_index_i      (dl_index_i),
		.dl_addr_i       (dl_addr_i),
		.dl_data_i       (dl_data_i),
		.dl_wr_i         (dl_wr_i),
		.load_addr_i     (load_addr),
		.load_cmd_o      (load_cmd),
		.dl_kind_o       (dl_kind),
		.dl_done_o       (dl_done),
		.chip_hdr_o      (chip_hdr),
		.chip_hdr_done_o (chip_hdr_done),
		.cart_id_o       (cart_id_o),
		.cart_exrom_o    (cart_exrom_o),
		.cart_game_o     (cart_game_o)
	);

	// Memory write path
	slot_write_scheduler u_slot_write_scheduler (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.load_cmd_i  (load_cmd),
		.slot_i      (slot_i),
		.host_addr_i (host_addr_i),
		.host_ce_i   (host_ce_i),
		.host_we_i   (host_we_i),
		.host_data_i (host_data_i),
		.load_addr_o (load_addr),
		.dl_wait_o   (dl_wait_o),
		.mem_addr_o  (mem_addr_o),
		.mem_ce_o    (mem_ce_o),
		.mem_we_o    (mem_we_o),
		.mem_data_o  (mem_data_o)
	);

	// Output side
	cart_status_regs u_cart_status_regs (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.dl_kind_i       (dl_kind),
		.dl_done_i       (dl_done),
		.chip_hdr_i      (chip_hdr),
		.chip_hdr_done_i (chip_hdr_done),
		.load_addr_i     (load_addr),
		.detach_i        (detach_i),
		.bank_o          (bank_o),
		.bank_raddr_o    (bank_raddr_o),
		.bank_wr_o       (bank_wr_o),
		.cart_attached_o (cart_attached_o)
	);

endmodule

`default_nettype wire

// ==== cart_status_regs.sv ====
// ==============================
// Cartridge status
// Attached flag and bank records with their memory address
// ==============================
`timescale 1ns/1ns
`default_nettype none

`include "cart_loader_consts.svh"

module cart_status_regs import cart_loader_pkg::*; (
	input  wire                     clk_sys,
	input  wire                     reset_n,
	input  dl_kind_e                dl_kind_i,
	input  wire                     dl_done_i,
	input  crt_bank_t               chip_hdr_i,
	input  wire                     chip_hdr_done_i,
	input  wire [`LOAD_ADDR_W-1:0]  load_addr_i,
	input  wire                     detach_i,
	output crt_bank_t               bank_o,
	output logic [`LOAD_ADDR_W-1:0] bank_raddr_o,
	output logic                    bank_wr_o,
	output logic                    cart_attached_o
);

	logic detach_q;
	logic crt_q;
	logic is_crt;
	logic crt_start;
	logic detach_rise;

	assign is_crt      = dl_kind_i == DL_CRT;
	assign crt_start   = is_crt & ~crt_q;
	assign detach_rise = detach_i & ~detach_q;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			detach_q        <= 1'b0;
			crt_q           <= 1'b0;
			bank_wr_o       <= 1'b0;
			cart_attached_o <= 1'b0;
		end else begin
			detach_q  <= detach_i;
			crt_q     <= is_crt;
			bank_wr_o <= chip_hdr_done_i;

			// A new image replaces the old one while PRG loads leave it alone
			if (detach_rise || crt_start)
				cart_attached_o <= 1'b0;
			else if (dl_done_i && is_crt)
				cart_attached_o <= 1'b1;
		end
	end

	// Load address is already on the 8 KB boundary of this chip
	always_ff @(posedge clk_sys) begin
		if (chip_hdr_done_i) begin
			bank_o       <= chip_hdr_i;
			bank_raddr_o <= load_addr_i;
		end
	end

endmodule

`default_nettype wire

// ==== crt_chip_parser.sv ====
// ==============================
// CRT image parser
// File header capture, CHIP header parsing and payload counting
// ==============================
`timescale 1ns/1ns
`default_nettype none

`include "cart_loader_consts.svh"

module crt_chip_parser import cart_loader_pkg::*; (
	input  wire                    clk_sys,
	input  wire                    reset_n,
	input  wire                    crt_byte_i,
	input  wire [`LOAD_ADDR_W-1:0] dl_addr_i,
	input  wire [7:0]              dl_data_i,
	input  wire [`LOAD_ADDR_W-1:0] load_addr_i,
	output load_cmd_t              load_cmd_o,
	output crt_bank_t              chip_hdr_o,
	output logic                   chip_hdr_done_o,
	output logic [15:0]            cart_id_o,
	output logic [7:0]             cart_exrom_o,
	output logic [7:0]             cart_game_o
);

	logic [31:0] blk_len;
	logic [3:0]  hdr_cnt;
	load_cmd_t   cmd_q;
	logic        hdr_done_q;
	crt_bank_t   hdr_q;
	logic        in_chips;
	logic        hdr_start;
	logic        aligned;

	assign in_chips  = dl_addr_i >= `CRT_CHIP_START;
	// A new CHIP packet starts once the previous block is used up
	assign hdr_start = in_chips && (blk_len == '0) && (hdr_cnt == '0);
	assign aligned   = load_addr_i[`CRT_ALIGN_BITS-1:0] == '0;

	// ==============================
	// Block and header counters
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			blk_len    <= '0;
			hdr_cnt    <= '0;
			cmd_q.op   <= OP_NONE;
			hdr_done_q <= 1'b0;
		end else begin
			cmd_q.op   <= OP_NONE;
			hdr_done_q <= 1'b0;

			if (crt_byte_i) begin
				cmd_q.data <= dl_data_i;

				if (dl_addr_i == '0) begin
					cmd_q.op <= OP_SET_BASE;
					blk_len  <= '0;
					hdr_cnt  <= '0;
				end

				if (in_chips) begin
					if (hdr_start) begin
						hdr_cnt <= 4'd1;
						// Each chip starts on the next 8 KB boundary
						if (!aligned)
							cmd_q.op <= OP_ALIGN;
					end else if (hdr_cnt != '0) begin
						if (hdr_cnt == 4'(`CHIP_HDR_LEN - 1))
							hdr_cnt <= '0;
						else
							hdr_cnt <= hdr_cnt + 1'b1;

						case (hdr_cnt)
							4'd4: blk_len[31:24] <= dl_data_i;
							4'd5: blk_len[23:16] <= dl_data_i;
							4'd6: blk_len[15:8]  <= dl_data_i;
							4'd7: blk_len[7:0]   <= dl_data_i;
							// Packet length includes its own header
							4'd8: blk_len <= blk_len - 32'(`CHIP_HDR_LEN);
							default: ;
						endcase

						if (hdr_cnt == 4'(`CHIP_HDR_LEN - 1))
							hdr_done_q <= 1'b1;
					end else begin
						blk_len  <= blk_len - 1'b1;
						cmd_q.op <= OP_WRITE;
					end
				end
			end
		end
	end

	// ==============================
	// Header field capture
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (crt_byte_i) begin
			if (dl_addr_i == `CRT_HDR_ID_HI)
				cart_id_o[15:8] <= dl_data_i;
			if (dl_addr_i == `CRT_HDR_ID_LO)
				cart_id_o[7:0] <= dl_data_i;
			if (dl_addr_i == `CRT_HDR_EXROM)
				cart_exrom_o <= dl_data_i;
			if (dl_addr_i == `CRT_HDR_GAME)
				cart_game_o <= dl_data_i;

			if (in_chips && hdr_cnt != '0) begin
				// Only the low byte of the chip type is kept
				case (hdr_cnt)
					4'd9:  hdr_q.bank_type       <= dl_data_i;
					4'd10: hdr_q.bank_num[15:8]  <= dl_data_i;
					4'd11: hdr_q.bank_num[7:0]   <= dl_data_i;
					4'd12: hdr_q.load_addr[15:8] <= dl_data_i;
					4'd13: hdr_q.load_addr[7:0]  <= dl_data_i;
					4'd14: hdr_q.size[15:8]      <= dl_data_i;
					4'd15: hdr_q.size[7:0]       <= dl_data_i;
					default: ;
				endcase
			end
		end
	end

	assign load_cmd_o      = cmd_q;
	assign chip_hdr_o      = hdr_q;
	assign chip_hdr_done_o = hdr_done_q;

endmodule

`default_nettype wire

// ==== dl_stream_decoder.sv ====
// ==============================
// Download stream decoder
// Classifies the file and turns PRG and CRT bytes into load commands
// ==============================
`timescale 1ns/1ns
`default_nettype none

`include "cart_loader_consts.svh"

module dl_stream_decoder import cart_loader_pkg::*; (
	input  wire                    clk_sys,
	input  wire                    reset_n,
	input  wire                    dl_active_i,
	input  wire [7:0]              dl_index_i,
	input  wire [`LOAD_ADDR_W-1:0] dl_addr_i,
	input  wire [7:0]              dl_data_i,
	input  wire                    dl_wr_i,
	input  wire [`LOAD_ADDR_W-1:0] load_addr_i,
	output load_cmd_t              load_cmd_o,
	output dl_kind_e               dl_kind_o,
	output logic                   dl_done_o,
	output crt_bank_t              chip_hdr_o,
	output logic                   chip_hdr_done_o,
	output logic [15:0]            cart_id_o,
	output logic [7:0]             cart_exrom_o,
	output logic [7:0]             cart_game_o
);

	function automatic dl_kind_e decode_kind(input logic [7:0] idx);
		dl_kind_e kind;
		if (idx == `IDX_PRG)
			kind = DL_PRG;
		else if (idx == `IDX_CRT || idx == `IDX_CRT_ALT)
			kind = DL_CRT;
		else
			kind = DL_NONE;
		return kind;
	endfunction

	logic      active_q;
	logic      done_q;
	dl_kind_e  kind_q;
	dl_kind_e  cur_kind;
	load_cmd_t prg_cmd_q;
	load_cmd_t crt_cmd;
	logic      dl_start;
	logic      crt_byte;

	// Kind is taken from the index in the first cycle of a download
	assign dl_start = dl_active_i & ~active_q;
	assign cur_kind = dl_start ? decode_kind(dl_index_i) : kind_q;
	assign crt_byte = dl_wr_i & (cur_kind == DL_CRT);

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			active_q     <= 1'b0;
			done_q       <= 1'b0;
			kind_q       <= DL_NONE;
			prg_cmd_q.op <= OP_NONE;
		end else begin
			active_q     <= dl_active_i;
			done_q       <= active_q & ~dl_active_i;
			prg_cmd_q.op <= OP_NONE;

			// Kind stays valid through the done cycle
			if (dl_start)
				kind_q <= decode_kind(dl_index_i);
			else if (done_q)
				kind_q <= DL_NONE;

			// PRG carries two little-endian address bytes before its payload
			if (dl_wr_i && cur_kind == DL_PRG) begin
				prg_cmd_q.data <= dl_data_i;
				if (dl_addr_i == '0)
					prg_cmd_q.op <= OP_SET_LO;
				else if (dl_addr_i == `LOAD_ADDR_W'd1)
					prg_cmd_q.op <= OP_SET_HI;
				else
					prg_cmd_q.op <= OP_WRITE;
			end
		end
	end

	crt_chip_parser u_crt_chip_parser (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.crt_byte_i      (crt_byte),
		.dl_addr_i       (dl_addr_i),
		.dl_data_i       (dl_data_i),
		.load_addr_i     (load_addr_i),
		.load_cmd_o      (crt_cmd),
		.chip_hdr_o      (chip_hdr_o),
		.chip_hdr_done_o (chip_hdr_done_o),
		.cart_id_o       (cart_id_o),
		.cart_exrom_o    (cart_exrom_o),
		.cart_game_o     (cart_game_o)
	);

	assign load_cmd_o = (kind_q == DL_CRT) ? crt_cmd : prg_cmd_q;
	assign dl_kind_o  = kind_q;
	assign dl_done_o  = done_q;

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
cart_loader_pkg.sv
crt_chip_parser.sv
dl_stream_decoder.sv
slot_write_scheduler.sv
cart_status_regs.sv
cart_loader_top.sv
tb_cart_loader.sv

// ==== slot_write_scheduler.sv ====
// ==============================
// Slot write scheduler
// Load address, one pending byte, writes inside loader memory slots
// ==============================
`timescale 1ns/1ns
`default_nettype none

`include "cart_loader_consts.svh"

module slot_write_scheduler import cart_loader_pkg::*; (
	input  wire                     clk_sys,
	input  wire                     reset_n,
	input  load_cmd_t               load_cmd_i,
	input  wire                     slot_i,
	input  wire [`LOAD_ADDR_W-1:0]  host_addr_i,
	input  wire                     host_ce_i,
	input  wire                     host_we_i,
	input  wire [7:0]               host_data_i,
	output logic [`LOAD_ADDR_W-1:0] load_addr_o,
	output logic                    dl_wait_o,
	output logic [`LOAD_ADDR_W-1:0] mem_addr_o,
	output logic                    mem_ce_o,
	output logic                    mem_we_o,
	output logic [7:0]              mem_data_o
);

	logic [`LOAD_ADDR_W-1:0] load_addr;
	logic                    pending;
	logic [7:0]              pend_data;
	logic                    slot_q;
	logic                    wr_arm;
	logic [`LOAD_ADDR_W-1:0] wr_addr;
	logic [7:0]              wr_data;
	logic                    slot_fall;
	logic                    slot_first;
	logic                    loader_wr;

	assign slot_fall  = slot_q & ~slot_i;
	assign slot_first = slot_i & ~slot_q;

	// ==============================
	// Load address and write pipeline
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			load_addr <= '0;
			pending   <= 1'b0;
			slot_q    <= 1'b0;
			wr_arm    <= 1'b0;
		end else begin
			slot_q <= slot_i;

			// Armed write is spent in the first cycle of the slot
			if (slot_first)
				wr_arm <= 1'b0;

			// Prepare between slots so the write is ready when the next one opens
			if (slot_fall && pending) begin
				pending   <= 1'b0;
				wr_arm    <= 1'b1;
				load_addr <= load_addr + 1'b1;
			end

			case (load_cmd_i.op)
				// PRG files always target the low 64 KB
				OP_SET_LO:   load_addr <= {{(`LOAD_ADDR_W-16){1'b0}}, load_addr[15:8],
				                           load_cmd_i.data};
				OP_SET_HI:   load_addr[15:8] <= load_cmd_i.data;
				OP_SET_BASE: load_addr <= `CRT_BASE_ADDR;
				OP_ALIGN:    load_addr <= {load_addr[`LOAD_ADDR_W-1:`CRT_ALIGN_BITS] + 1'b1,
				                           {`CRT_ALIGN_BITS{1'b0}}};
				OP_WRITE:    pending <= 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (load_cmd_i.op == OP_WRITE)
			pend_data <= load_cmd_i.data;
		if (slot_fall && pending) begin
			wr_addr <= load_addr;
			wr_data <= pend_data;
		end
	end

	// Wait covers the command cycle too, before pending is set
	assign dl_wait_o   = pending | (load_cmd_i.op == OP_WRITE);
	assign load_addr_o = load_addr;

	// ==============================
	// Memory port mux
	// ==============================
	assign loader_wr  = slot_first & wr_arm;
	assign mem_addr_o = slot_i ? wr_addr : host_addr_i;
	assign mem_ce_o   = slot_i ? loader_wr : host_ce_i;
	assign mem_we_o   = slot_i ? loader_wr : host_we_i;
	assign mem_data_o = slot_i ? wr_data : host_data_i;

endmodule

`default_nettype wire

// ==== tb_cart_loader.sv ====
// ==============================
// Cartridge loader testbench
// PRG and CRT downloads against a slot driven memory model
// ==============================
`timescale 1ns/1ns
`default_nettype none

`include "cart_loader_consts.svh"

module tb_cart_loader import cart_loader_pkg::*; ();

	logic                    clk_sys;
	logic                    reset_n;
	logic                    dl_active_i;
	logic [7:0]              dl_index_i;
	logic [`LOAD_ADDR_W-1:0] dl_addr_i;
	logic [7:0]              dl_data_i;
	logic                    dl_wr_i;
	logic                    slot_i;
	logic [`LOAD_ADDR_W-1:0] host_addr_i;
	logic                    host_ce_i;
	logic                    host_we_i;
	logic [7:0]              host_data_i;
	logic                    detach_i;
	wire                     dl_wait_o;
	wire [`LOAD_ADDR_W-1:0]  mem_addr_o;
	wire                     mem_ce_o;
	wire                     mem_we_o;
	wire [7:0]               mem_data_o;
	wire [15:0]              cart_id_o;
	wire [7:0]               cart_exrom_o;
	wire [7:0]               cart_game_o;
	crt_bank_t               bank_o;
	wire [`LOAD_ADDR_W-1:0]  bank_raddr_o;
	wire                     bank_wr_o;
	wire                     cart_attached_o;

	integer                  seed;
	logic [2:0]              slot_cnt;
	logic                    slot_prev;
	logic [7:0]              mem_model [int];
	int                      wr_cnt [int];
	int                      loader_writes;
	int                      addr_key;
	logic [7:0]              file_q [$];
	logic [7:0]              payload_q [$];
	crt_bank_t               bank_q [$];
	logic [`LOAD_ADDR_W-1:0] raddr_q [$];
	logic                    attach_watch;
	logic                    attach_ref;

	cart_loader_top i_dut (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.dl_active_i     (dl_active_i),
		.dl_index_i      (dl_index_i),
		.dl_addr_i       (dl_addr_i),
		.dl_data_i       (dl_data_i),
		.dl_wr_i         (dl_wr_i),
		.slot_i          (slot_i),
		.host_addr_i     (host_addr_i),
		.host_ce_i       (host_ce_i),
		.host_we_i       (host_we_i),
		.host_data_i     (host_data_i),
		.detach_i        (detach_i),
		.dl_wait_o       (dl_wait_o),
		.mem_addr_o      (mem_addr_o),
		.mem_ce_o        (mem_ce_o),
		.mem_we_o        (mem_we_o),
		.mem_data_o      (mem_data_o),
		.cart_id_o       (cart_id_o),
		.cart_exrom_o    (cart_exrom_o),
		.cart_game_o     (cart_game_o),
		.bank_o          (bank_o),
		.bank_raddr_o    (bank_raddr_o),
		.bank_wr_o       (bank_wr_o),
		.cart_attached_o (cart_attached_o)
	);

	always #4 clk_sys = ~clk_sys;

	// Loader slot for 2 of every 6 cycles and random host traffic
	always @(posedge clk_sys) begin
		slot_cnt    <= (slot_cnt == 3'd5) ? 3'd0 : slot_cnt + 3'd1;
		slot_i      <= (slot_cnt < 3'd2);
		host_addr_i <= $random(seed);
		host_ce_i   <= $random(seed);
		host_we_i   <= $random(seed);
		host_data_i <= $random(seed);
	end

	// ==============================
	// Checks and helper tasks
	// ==============================
	task automatic abort_run();
		$display("Test FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %0t ns %s: expected %h, got %h", $time, name, exp, got);
			abort_run();
		end
	endtask

	// Memory model, port sharing and back-pressure checked at the falling edge
	always @(negedge clk_sys) begin
		if (!slot_i) begin
			check_value("mem_addr_o", mem_addr_o, host_addr_i);
			check_value("mem_ce_o", mem_ce_o, host_ce_i);
			check_value("mem_we_o", mem_we_o, host_we_i);
			check_value("mem_data_o", mem_data_o, host_data_i);
		end else if (mem_ce_o || mem_we_o) begin
			assert (!slot_prev && mem_ce_o && mem_we_o) else begin
				$display("Loader write outside the first cycle of a slot at %0t ns", $time);
				abort_run();
			end
			addr_key            = int'(mem_addr_o);
			mem_model[addr_key] = mem_data_o;
			wr_cnt[addr_key]    = wr_cnt.exists(addr_key) ? wr_cnt[addr_key] + 1 : 1;
			loader_writes       = loader_writes + 1;
		end
		assert (!(dl_wr_i && dl_wait_o)) else begin
			$display("Byte strobe sent while dl_wait_o was high at %0t ns", $time);
			abort_run();
		end
		if (attach_watch)
			check_value("cart_attached_o", cart_attached_o, attach_ref);
		if (reset_n && bank_wr_o) begin
			bank_q.push_back(bank_o);
			raddr_q.push_back(bank_raddr_o);
		end
		slot_prev = slot_i;
	end

	task automatic wait_ready();
		int n;
		n = 0;
		@(negedge clk_sys);
		while (dl_wait_o) begin
			n++;
			if (n > 40) begin
				$display("Timeout waiting for dl_wait_o to fall");
				abort_run();
			end
			@(negedge clk_sys);
		end
	endtask

	task automatic wait_slot(input logic level);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (slot_i !== level) begin
			n++;
			if (n > 20) begin
				$display("Timeout waiting for slot_i to become %b", level);
				abort_run();
			end
			@(negedge clk_sys);
		end
	endtask

	task automatic wait_attached(input logic level);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (cart_attached_o !== level) begin
			n++;
			if (n > 20) begin
				$display("Timeout waiting for cart_attached_o to become %b", level);
				abort_run();
			end
			@(negedge clk_sys);
		end
	endtask

	task automatic send_byte(input int offs, input logic [7:0] data);
		@(posedge clk_sys);
		dl_addr_i <= `LOAD_ADDR_W'(offs);
		dl_data_i <= data;
		dl_wr_i   <= 1'b1;
		@(posedge clk_sys);
		dl_wr_i   <= 1'b0;
		wait_ready();
	endtask

	task automatic stream_file(input logic [7:0] idx);
		@(posedge clk_sys);
		dl_active_i <= 1'b1;
		dl_index_i  <= idx;
		for (int i = 0; i < file_q.size(); i++)
			send_byte(i, file_q[i]);
		// Last armed write goes out in the next slot
		wait_slot(1'b1);
		wait_slot(1'b0);
		@(posedge clk_sys);
		dl_active_i <= 1'b0;
	endtask

	task automatic clear_model();
		mem_model.delete();
		wr_cnt.delete();
		loader_writes = 0;
		file_q.delete();
		payload_q.delete();
	endtask

	task automatic push_word(input logic [15:0] w);
		file_q.push_back(w[15:8]);
		file_q.push_back(w[7:0]);
	endtask

	task automatic build_prg(input int n);
		logic [7:0] b;
		push_word(16'h0108);
		for (int i = 0; i < n; i++) begin
			b = $random(seed);
			file_q.push_back(b);
			payload_q.push_back(b);
		end
	endtask

	// CHIP packet whose length counts the 16 header bytes
	task automatic push_chip(input logic [15:0] btype, input logic [15:0] bnum,
		input logic [15:0] laddr, input logic [15:0] size);
		logic [31:0] len;
		logic [7:0]  b;
		len = 32'(size) + 32'd16;
		push_word(16'h4348);
		push_word(16'h4950);
		push_word(len[31:16]);
		push_word(len[15:0]);
		push_word(btype);
		push_word(bnum);
		push_word(laddr);
		push_word(size);
		for (int i = 0; i < size; i++) begin
			b = $random(seed);
			file_q.push_back(b);
			payload_q.push_back(b);
		end
	endtask

	task automatic check_block(input int base, input int first, input int n);
		for (int i = 0; i < n; i++) begin
			if (!mem_model.exists(base + i)) begin
				$display("No loader write reached address %h", base + i);
				abort_run();
			end else begin
				check_value($sformatf("mem[%h]", base + i), mem_model[base + i],
					payload_q[first + i]);
				check_value($sformatf("write count at %h", base + i), wr_cnt[base + i], 1);
			end
		end
	endtask

	task automatic check_bank(input int k, input crt_bank_t exp, input logic [31:0] raddr);
		check_value("bank_o.bank_type", bank_q[k].bank_type, exp.bank_type);
		check_value("bank_o.bank_num", bank_q[k].bank_num, exp.bank_num);
		check_value("bank_o.load_addr", bank_q[k].load_addr, exp.load_addr);
		check_value("bank_o.size", bank_q[k].size, exp.size);
		check_value("bank_raddr_o", raddr_q[k], raddr);
	endtask

	// ==============================
	// Test sequence
	// ==============================
	initial begin
		clk_sys       = 1'b0;
		reset_n       = 1'b0;
		dl_active_i   = 1'b0;
		dl_index_i    = 8'h00;
		dl_addr_i     = '0;
		dl_data_i     = 8'h00;
		dl_wr_i       = 1'b0;
		slot_i        = 1'b0;
		host_addr_i   = '0;
		host_ce_i     = 1'b0;
		host_we_i     = 1'b0;
		host_data_i   = 8'h00;
		detach_i      = 1'b0;
		seed          = 32'h5a20;
		slot_cnt      = 3'd0;
		slot_prev     = 1'b0;
		loader_writes = 0;
		attach_watch  = 1'b0;
		attach_ref    = 1'b0;
		repeat (5) @(posedge clk_sys);
		reset_n <= 1'b1;
		@(negedge clk_sys);
		check_value("dl_wait_o", dl_wait_o, 0);
		check_value("bank_wr_o", bank_wr_o, 0);
		check_value("cart_attached_o", cart_attached_o, 0);

		// PRG at 0801 with no cartridge
		clear_model();
		build_prg(20);
		attach_watch = 1'b1;
		attach_ref   = 1'b0;
		stream_file(`IDX_PRG);
		wait_slot(1'b1);
		wait_slot(1'b0);
		attach_watch = 1'b0;
		check_block(32'h0801, 0, 20);
		check_value("loader writes", loader_writes, 20);

		// CRT with an odd sized first chip
		clear_model();
		bank_q.delete();
		raddr_q.delete();
		for (int i = 0; i < 64; i++)
			file_q.push_back(8'(i) ^ 8'h5a);
		file_q[`CRT_HDR_ID_HI] = 8'h12;
		file_q[`CRT_HDR_ID_LO] = 8'h34;
		file_q[`CRT_HDR_EXROM] = 8'h01;
		file_q[`CRT_HDR_GAME]  = 8'h00;
		push_chip(16'h0000, 16'h0000, 16'h8000, 16'd7);
		push_chip(16'h0002, 16'h0001, 16'ha000, 16'd5);
		// No cartridge is attached until the download has ended
		attach_watch = 1'b1;
		attach_ref   = 1'b0;
		stream_file(`IDX_CRT);
		attach_watch = 1'b0;
		wait_attached(1'b1);
		check_value("cart_id_o", cart_id_o, 16'h1234);
		check_value("cart_exrom_o", cart_exrom_o, 8'h01);
		check_value("cart_game_o", cart_game_o, 8'h00);
		check_value("bank_wr_o pulses", bank_q.size(), 2);
		check_bank(0, {8'h00, 16'h0000, 16'h8000, 16'd7}, 32'h100000);
		check_bank(1, {8'h02, 16'h0001, 16'ha000, 16'd5}, 32'h102000);
		check_block(32'h100000, 0, 7);
		check_block(32'h102000, 7, 5);
		check_value("loader writes", loader_writes, 12);

		// PRG leaves the attached cartridge alone
		clear_model();
		build_prg(9);
		attach_watch = 1'b1;
		attach_ref   = 1'b1;
		stream_file(`IDX_PRG);
		wait_slot(1'b1);
		wait_slot(1'b0);
		attach_watch = 1'b0;
		check_block(32'h0801, 0, 9);
		check_value("loader writes", loader_writes, 9);

		// Detach pulse
		@(posedge clk_sys);
		detach_i <= 1'b1;
		@(posedge clk_sys);
		detach_i <= 1'b0;
		wait_attached(1'b0);

		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire
